// File: rtl/bpu_pkg.sv
// Branch predictor types
package bpu_pkg;

    localparam int ADDR_WIDTH = 32;                 // Instruction address width

    typedef logic [ADDR_WIDTH-1:0] addr_t;          // Instruction address

    // Direction counter, 0 strongly not-taken up to 3 strongly taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_RESET = 2'd1;              // Weakly not-taken after reset

    typedef enum logic {
        BR_COND = 1'b0,                             // Conditional branch
        BR_JUMP = 1'b1                              // Unconditional jump
    } br_type_e;

    // Payload stored per target buffer entry
    typedef struct packed {
        br_type_e br_type;
        addr_t    target;
    } ftb_data_t;

    // Fetch query
    typedef struct packed {
        addr_t pc;
    } bpu_query_t;

    // Resolved branch from execute
    typedef struct packed {
        addr_t    pc;
        br_type_e br_type;
        logic     taken;                            // Resolved direction
        addr_t    target;
    } bpu_update_t;

    // Prediction returned to fetch
    typedef struct packed {
        addr_t pc;                                  // Pc of the answered query
        logic  hit;                                 // Target buffer entry matched
        logic  taken;                               // Predicted taken
        addr_t target;                              // Stored target, 0 on a miss
        addr_t next_pc;                             // Next fetch address
    } bpu_pred_t;

endpackage

// File: rtl/bpu_bram.sv
// Simple dual-port block memory
`timescale 1ns/10ps

module bpu_bram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_BITS  = 6
) (
    input  logic                  clk,

    // Read port, always enabled
    input  logic [ADDR_BITS-1:0]  rd_addr_i,
    output logic [DATA_WIDTH-1:0] rd_data_o,

    // Write port
    input  logic                  wr_en_i,
    input  logic [ADDR_BITS-1:0]  wr_addr_i,
    input  logic [DATA_WIDTH-1:0] wr_data_i
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Read-first: a write to the read address shows up one cycle later
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: rtl/ftb.sv
// Branch target buffer
`timescale 1ns/10ps

module ftb
    import bpu_pkg::*;
#(
    parameter int FTB_DEPTH = 64
) (
    input  logic        clk,
    input  logic        arst_n_i,

    // Query stream
    input  logic        query_valid_i,
    input  bpu_query_t  query_i,

    // Update stream
    input  logic        update_valid_i,
    input  bpu_update_t update_i,

    // Lookup result, one cycle after the query
    output logic        hit_o,
    output ftb_data_t   data_o,
    output addr_t       pc_o
);

    localparam int IDX_BITS = $clog2(FTB_DEPTH);
    localparam int TAG_BITS = ADDR_WIDTH - IDX_BITS - 2;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // Memory word, tag kept next to the payload
    typedef struct packed {
        tag_t      tag;
        ftb_data_t data;
    } entry_t;

    idx_t                 query_idx;
    idx_t                 update_idx;
    tag_t                 query_tag_q;
    entry_t               wr_entry;
    entry_t               rd_entry;
    logic [FTB_DEPTH-1:0] valid_q;                  // Per-entry valid bits
    logic                 entry_valid_q;            // Valid bit read at query index
    logic                 query_valid_q;
    addr_t                query_pc_q;

    assign query_idx  = query_i.pc[IDX_BITS+1:2];
    assign update_idx = update_i.pc[IDX_BITS+1:2];

    assign wr_entry.tag          = update_i.pc[ADDR_WIDTH-1:IDX_BITS+2];
    assign wr_entry.data.br_type = update_i.br_type;
    assign wr_entry.data.target  = update_i.target;

    bpu_bram #(
        .DATA_WIDTH ($bits(entry_t)),
        .ADDR_BITS  (IDX_BITS)
    ) u_bram (
        .clk        (clk),
        .rd_addr_i  (query_idx),
        .rd_data_o  (rd_entry),
        .wr_en_i    (update_valid_i),
        .wr_addr_i  (update_idx),
        .wr_data_i  (wr_entry)
    );

    // Valid bits live in flops so reset can clear them
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q       <= '0;
            entry_valid_q <= 1'b0;
            query_valid_q <= 1'b0;
        end else begin
            entry_valid_q <= valid_q[query_idx];    // Old value on a same-edge update
            query_valid_q <= query_valid_i;
            if (update_valid_i) begin
                valid_q[update_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        query_pc_q <= query_i.pc;
    end

    assign query_tag_q = query_pc_q[ADDR_WIDTH-1:IDX_BITS+2];

    assign hit_o  = query_valid_q && entry_valid_q && (rd_entry.tag == query_tag_q);
    assign data_o = rd_entry.data;
    assign pc_o   = query_pc_q;

endmodule

// File: rtl/pht.sv
// Direction counter table
`timescale 1ns/10ps

module pht
    import bpu_pkg::*;
#(
    parameter int PHT_DEPTH = 256
) (
    input  logic        clk,
    input  logic        arst_n_i,

    // Query stream
    input  bpu_query_t  query_i,

    // Update stream
    input  logic        update_valid_i,
    input  bpu_update_t update_i,

    // Counter at the query index, one cycle later
    output ctr_t        ctr_o
);

    localparam int IDX_BITS = $clog2(PHT_DEPTH);

    typedef logic [IDX_BITS-1:0] idx_t;

    ctr_t ctr_q [PHT_DEPTH];
    idx_t query_idx;
    idx_t update_idx;
    ctr_t cur_ctr;
    ctr_t next_ctr;
    logic update_en;

    assign query_idx  = query_i.pc[IDX_BITS+1:2];
    assign update_idx = update_i.pc[IDX_BITS+1:2];
    assign update_en  = update_valid_i && (update_i.br_type == BR_COND);  // Jumps leave counters alone

    assign cur_ctr = ctr_q[update_idx];

    // Saturating step toward the resolved direction
    always_comb begin
        next_ctr = cur_ctr;
        if (update_i.taken) begin
            if (cur_ctr != 2'd3) begin
                next_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != 2'd0) begin
                next_ctr = cur_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
            ctr_o <= CTR_RESET;
        end else begin
            ctr_o <= ctr_q[query_idx];              // Sees the value before this edge's update
            if (update_en) begin
                ctr_q[update_idx] <= next_ctr;
            end
        end
    end

endmodule

// File: rtl/bpu_next_pc.sv
// Next fetch address selection
`timescale 1ns/10ps

module bpu_next_pc
    import bpu_pkg::*;
(
    input  addr_t     pc_i,                         // Registered query pc
    input  logic      hit_i,
    input  ftb_data_t data_i,
    input  ctr_t      ctr_i,
    output bpu_pred_t pred_o
);

    addr_t seq_pc;
    logic  pred_taken;

    assign seq_pc = pc_i + ADDR_WIDTH'(4);          // One 4-byte instruction per fetch

    // Jumps are always taken, conditionals follow the counter's top bit
    always_comb begin
        pred_taken = 1'b0;
        if (hit_i) begin
            if (data_i.br_type == BR_JUMP) begin
                pred_taken = 1'b1;
            end else begin
                pred_taken = ctr_i[1];
            end
        end
    end

    always_comb begin
        pred_o.pc      = pc_i;
        pred_o.hit     = hit_i;
        pred_o.taken   = pred_taken;
        pred_o.target  = hit_i ? data_i.target : '0;    // No target on a miss
        pred_o.next_pc = pred_taken ? data_i.target : seq_pc;
    end

endmodule

// File: rtl/bpu.sv
// Branch prediction unit
`timescale 1ns/10ps

module bpu
    import bpu_pkg::*;
#(
    parameter int FTB_DEPTH = 64,
    parameter int PHT_DEPTH = 256
) (
    input  logic        clk,
    input  logic        arst_n_i,

    // Query stream from fetch
    input  logic        query_valid_i,
    input  bpu_query_t  query_i,

    // Update stream from execute
    input  logic        update_valid_i,
    input  bpu_update_t update_i,

    // Prediction, one cycle after the query
    output logic        pred_valid_o,
    output bpu_pred_t   pred_o
);

    logic      ftb_hit;
    ftb_data_t ftb_data;
    addr_t     ftb_pc;
    ctr_t      pht_ctr;

    ftb #(
        .FTB_DEPTH      (FTB_DEPTH)
    ) u_ftb (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .query_valid_i  (query_valid_i),
        .query_i        (query_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .hit_o          (ftb_hit),
        .data_o         (ftb_data),
        .pc_o           (ftb_pc)
    );

    pht #(
        .PHT_DEPTH      (PHT_DEPTH)
    ) u_pht (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .query_i        (query_i),
        .update_valid_i (update_valid_i),
        .update_i       (update_i),
        .ctr_o          (pht_ctr)
    );

    bpu_next_pc u_next_pc (
        .pc_i           (ftb_pc),
        .hit_i          (ftb_hit),
        .data_i         (ftb_data),
        .ctr_i          (pht_ctr),
        .pred_o         (pred_o)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= query_valid_i;          // Matches the one-cycle lookup
        end
    end

endmodule

// File: test/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// File: test/bpu_tb.sv
// Branch predictor testbench
`timescale 1ns/10ps

module bpu_tb
    import bpu_pkg::*;
;

    localparam int FTB_DEPTH    = 64;
    localparam int PHT_DEPTH    = 256;
    localparam int FTB_IDX_BITS = 6;
    localparam int FTB_TAG_BITS = 24;
    localparam int PHT_IDX_BITS = 8;
    localparam int STIM_DELAY   = 10;                 // ns after the rising edge
    localparam int RAND_CYCLES  = 400;
    // Reset, then tests 1 to 6, then margin
    localparam int TEST_CYCLES  = 5 + 7 + 3 + 12 + 3 + 6 + RAND_CYCLES;
    localparam int MAX_CYCLES   = TEST_CYCLES + 100;

    logic        clk;
    logic        arst_n;
    logic        query_valid;
    bpu_query_t  query;
    logic        update_valid;
    bpu_update_t update;
    logic        pred_valid;
    bpu_pred_t   pred;

    // Reference model state
    logic [FTB_TAG_BITS-1:0] m_tag   [FTB_DEPTH];
    logic                    m_valid [FTB_DEPTH];
    ftb_data_t               m_data  [FTB_DEPTH];
    ctr_t                    m_ctr   [PHT_DEPTH];

    bpu_pred_t last_pred;                             // Response to the latest query
    int        cycle_count;
    integer    seed;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) u_clock (
        .clk_o        (clk),
        .arst_n_o     (arst_n)
    );

    bpu #(
        .FTB_DEPTH      (FTB_DEPTH),
        .PHT_DEPTH      (PHT_DEPTH)
    ) dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .query_valid_i  (query_valid),
        .query_i        (query),
        .update_valid_i (update_valid),
        .update_i       (update),
        .pred_valid_o   (pred_valid),
        .pred_o         (pred)
    );

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp, act);
        stop_failed();
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (exp !== act) begin
            report_mismatch("pred_valid_o", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_pred(input bpu_pred_t exp, input bpu_pred_t act);
        if (exp.pc !== act.pc) begin
            report_mismatch("pred_o.pc", exp.pc, act.pc);
        end
        if (exp.hit !== act.hit) begin
            report_mismatch("pred_o.hit", 32'(exp.hit), 32'(act.hit));
        end
        if (exp.taken !== act.taken) begin
            report_mismatch("pred_o.taken", 32'(exp.taken), 32'(act.taken));
        end
        if (exp.target !== act.target) begin
            report_mismatch("pred_o.target", exp.target, act.target);
        end
        if (exp.next_pc !== act.next_pc) begin
            report_mismatch("pred_o.next_pc", exp.next_pc, act.next_pc);
        end
    endtask

    // Explicit expectation for the directed tests
    function automatic bpu_pred_t expect_pred(input addr_t pc, input logic hit,
                                              input logic taken, input addr_t target);
        bpu_pred_t p;
        p.pc      = pc;
        p.hit     = hit;
        p.taken   = taken;
        p.target  = target;
        p.next_pc = taken ? target : pc + 32'd4;
        return p;
    endfunction

    function automatic bpu_update_t make_update(input addr_t pc, input br_type_e bt,
                                                input logic taken, input addr_t target);
        bpu_update_t u;
        u.pc      = pc;
        u.br_type = bt;
        u.taken   = taken;
        u.target  = target;
        return u;
    endfunction

    function automatic bpu_pred_t model_predict(input addr_t pc);
        bpu_pred_t                 p;
        logic [FTB_IDX_BITS-1:0]   idx;
        logic [PHT_IDX_BITS-1:0]   cidx;
        idx       = pc[FTB_IDX_BITS+1:2];
        cidx      = pc[PHT_IDX_BITS+1:2];
        p.pc      = pc;
        p.hit     = m_valid[idx] && (m_tag[idx] == pc[31:FTB_IDX_BITS+2]);
        p.taken   = 1'b0;
        p.target  = '0;
        if (p.hit) begin
            p.target = m_data[idx].target;
            p.taken  = (m_data[idx].br_type == BR_JUMP) ? 1'b1 : m_ctr[cidx][1];
        end
        p.next_pc = p.taken ? p.target : pc + 32'd4;
        return p;
    endfunction

    task automatic model_update(input bpu_update_t u);
        logic [FTB_IDX_BITS-1:0] idx;
        logic [PHT_IDX_BITS-1:0] cidx;
        idx               = u.pc[FTB_IDX_BITS+1:2];
        cidx              = u.pc[PHT_IDX_BITS+1:2];
        m_valid[idx]      = 1'b1;
        m_tag[idx]        = u.pc[31:FTB_IDX_BITS+2];
        m_data[idx].br_type = u.br_type;
        m_data[idx].target  = u.target;
        if (u.br_type == BR_COND) begin
            if (u.taken && m_ctr[cidx] != 2'd3) begin
                m_ctr[cidx] = m_ctr[cidx] + 2'd1;
            end else if (!u.taken && m_ctr[cidx] != 2'd0) begin
                m_ctr[cidx] = m_ctr[cidx] - 2'd1;
            end
        end
    endtask

    // Drive one cycle, then check the answer after the next edge
    task automatic run_cycle(input logic qv, input addr_t qpc, input logic uv,
                             input bpu_update_t upd);
        bpu_pred_t exp_pred;
        query_valid  = qv;
        query.pc     = qpc;
        update_valid = uv;
        update       = upd;
        exp_pred     = model_predict(qpc);      // Old contents on a same-edge update
        if (uv) begin
            model_update(upd);
        end
        @(posedge clk);
        #STIM_DELAY;
        check_valid(qv, pred_valid);
        if (qv) begin
            check_pred(exp_pred, pred);
        end
        last_pred = pred;
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic test_reset_misses();
        addr_t pcs [4];
        pcs = '{32'h0000_1000, 32'h0000_2004, 32'h8000_00fc, 32'h1234_5678};
        check_valid(1'b0, pred_valid);
        idle_cycle();
        idle_cycle();
        foreach (pcs[i]) begin
            run_cycle(1'b1, pcs[i], 1'b0, '0);
            check_pred(expect_pred(pcs[i], 1'b0, 1'b0, '0), last_pred);
        end
        idle_cycle();
    endtask

    task automatic test_jump_hit();
        run_cycle(1'b0, '0, 1'b1, make_update(32'h0000_0040, BR_JUMP, 1'b1, 32'h0000_0800));
        run_cycle(1'b1, 32'h0000_0040, 1'b0, '0);
        check_pred(expect_pred(32'h0000_0040, 1'b1, 1'b1, 32'h0000_0800), last_pred);
        run_cycle(1'b1, 32'h0000_0140, 1'b0, '0);   // Same index, other tag
        check_pred(expect_pred(32'h0000_0140, 1'b0, 1'b0, '0), last_pred);
    endtask

    task automatic test_cond_counter();
        logic  outcome [6];
        logic  exp_taken [6];
        addr_t pc;
        addr_t tgt;
        pc        = 32'h0000_0208;
        tgt       = 32'h0000_0a00;
        outcome   = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
        exp_taken = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};   // Counter 0 1 2 3 3 2
        foreach (outcome[i]) begin
            run_cycle(1'b0, '0, 1'b1, make_update(pc, BR_COND, outcome[i], tgt));
            run_cycle(1'b1, pc, 1'b0, '0);
            check_pred(expect_pred(pc, 1'b1, exp_taken[i], tgt), last_pred);
        end
    endtask

    task automatic test_same_edge();
        addr_t pc;
        pc = 32'h0000_0310;
        run_cycle(1'b0, '0, 1'b1, make_update(pc, BR_JUMP, 1'b1, 32'h0000_1100));
        run_cycle(1'b1, pc, 1'b1, make_update(pc, BR_JUMP, 1'b1, 32'h0000_2200));
        check_pred(expect_pred(pc, 1'b1, 1'b1, 32'h0000_1100), last_pred);
        run_cycle(1'b1, pc, 1'b0, '0);
        check_pred(expect_pred(pc, 1'b1, 1'b1, 32'h0000_2200), last_pred);
    endtask

    task automatic test_back_to_back();
        addr_t pcs [6];
        pcs = '{32'h0000_0040, 32'h0000_0140, 32'h0000_0208,
                32'h0000_0310, 32'h0000_0400, 32'h0000_0044};
        foreach (pcs[i]) begin
            run_cycle(1'b1, pcs[i], 1'b0, '0);
        end
    endtask

    // Small address set so that entries get hit and replaced
    task automatic test_random();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        addr_t       qpc;
        addr_t       upc;
        br_type_e    bt;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r   = $random(seed);
            r2  = $random(seed);
            r3  = $random(seed);
            qpc = {22'd0, r[1:0], 3'd0, r[4:2], 2'b00};
            upc = {22'd0, r2[1:0], 3'd0, r2[4:2], 2'b00};
            bt  = (r2[6:5] == 2'b00) ? BR_JUMP : BR_COND;
            run_cycle(r[5], qpc, r[6], make_update(upc, bt, r2[7], {r3[29:0], 2'b00}));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            stop_failed();
        end
    end

    initial begin
        query_valid  = 1'b0;
        query        = '0;
        update_valid = 1'b0;
        update       = '0;
        last_pred    = '0;
        cycle_count  = 0;
        seed         = 32'h63d15234;
        for (int i = 0; i < FTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_data[i]  = '0;
        end
        for (int i = 0; i < PHT_DEPTH; i++) begin
            m_ctr[i] = 2'd1;                          // Weakly not-taken
        end
        @(posedge arst_n);
        @(posedge clk);
        #STIM_DELAY;
        test_reset_misses();
        test_jump_hit();
        test_cond_counter();
        test_same_edge();
        test_back_to_back();
        test_random();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: list.f
rtl/bpu_pkg.sv
rtl/bpu_bram.sv
rtl/ftb.sv
rtl/pht.sv
rtl/bpu_next_pc.sv
rtl/bpu.sv
test/tb_clock.sv
test/bpu_tb.sv

// File: Makefile
# Verilator build for the branch prediction unit

VERILATOR ?= verilator
TOP       ?= bpu_tb
SEED_ARGS ?= +verilator+seed+1
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a failing exit status
run: compile
	./$(SIM_BIN) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
